// ==== Makefile ====
# Verilator build and run of the capture control slave testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, search the log for the pass message"
	@echo "make clean  remove obj_dir and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --assert -Wno-fatal --top-module capture_ctrl_slave_tb -f capture_ctrl_slave.f
	./obj_dir/Vcapture_ctrl_slave_tb +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/capture_ctrl_slave_props.sv ====
`timescale 1ns/1ns
module capture_ctrl_slave_props (
    input logic                     clk,
    input logic                     hdmi_rstn_sync,
    input logic                     aw_valid,
    input logic                     aw_ready,
    input logic                     w_ready,
    input capture_ctrl_pkg::axi_b_t b,
    input logic                     b_valid,
    input logic                     b_ready,
    input logic                     ar_valid,
    input logic                     ar_ready,
    input capture_ctrl_pkg::axi_r_t r,
    input logic                     r_valid,
    input logic                     r_ready,
    input logic                     add_need_frame
);

    int n_b_hold = 0;
    int n_r_hold = 0;
    int n_w_lat = 0;
    int n_r_lat = 0;
    int n_pulse = 0;
    int n_reset = 0;
    int fail_cnt;

    assign fail_cnt = n_b_hold + n_r_hold + n_w_lat + n_r_lat + n_pulse + n_reset;

    assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
                     b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
        $error("b_valid dropped or b changed while b_ready was low");
        n_b_hold = n_b_hold + 1;
    end

    assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
                     r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
        $error("r_valid dropped or r changed while r_ready was low");
        n_r_hold = n_r_hold + 1;
    end

    assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
                     aw_valid && aw_ready |=> w_ready)
    else begin
        $error("w_ready not high one cycle after AW accept");
        n_w_lat = n_w_lat + 1;
    end

    assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
                     ar_valid && ar_ready |=> r_valid)
    else begin
        $error("r_valid not high one cycle after AR accept");
        n_r_lat = n_r_lat + 1;
    end

    assert property (@(posedge clk) disable iff (!hdmi_rstn_sync)
                     add_need_frame |=> !add_need_frame)
    else begin
        $error("add_need_frame high for more than one cycle");
        n_pulse = n_pulse + 1;
    end

    assert property (@(posedge clk) $rose(hdmi_rstn_sync) |->
                     aw_ready && ar_ready && !w_ready && !b_valid && !r_valid)
    else begin
        $error("handshake outputs not in reset state after reset release");
        n_reset = n_reset + 1;
    end

endmodule

bind capture_ctrl_slave capture_ctrl_slave_props u_props (.*);

// ==== bench/capture_ctrl_slave_tb.sv ====
`timescale 1ns/1ns
module capture_ctrl_slave_tb;

    localparam int TEST_BEATS  = 8 + 4 + 7 + 10 + 84 + 1;
    localparam int CYCLE_LIMIT = 6 * TEST_BEATS + 10;

    logic                              clk = 1'b0;
    logic                              hdmi_rstn_sync;
    capture_ctrl_pkg::axi_aw_t         aw;
    capture_ctrl_pkg::axi_aw_t         ar;
    capture_ctrl_pkg::axi_w_t          w;
    capture_ctrl_pkg::axi_b_t          b;
    capture_ctrl_pkg::axi_r_t          r;
    capture_ctrl_pkg::capture_status_t status;
    capture_ctrl_pkg::capture_ctrl_t   ctrl;
    logic                              aw_valid, aw_ready, w_valid, w_ready;
    logic                              b_valid, b_ready, ar_valid, ar_ready;
    logic                              r_valid, r_ready, add_need_frame;

    logic [31:0] lfsr = 32'hd2aa8885;
    logic [31:0] model [0:4]; // writable registers, ctrl word masked to bits 0 and 8
    logic [31:0] wdata [0:255];
    int          errors = 0;
    int          err_mark = 0;
    int          tests_failed = 0;
    int          pulses = 0;
    int          pulses_before;

    capture_ctrl_slave uut (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (add_need_frame)
            pulses <= pulses + 1; // mid-cycle sample
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 32; i++)
            v = {v[30:0], rand_bit()};
        return v;
    endfunction

    // codes 2 and 3 are reserved
    function automatic logic [1:0] resp_for(logic [1:0] burst);
        return burst[1] ? capture_ctrl_pkg::RESP_SLVERR : capture_ctrl_pkg::RESP_OKAY;
    endfunction

    function automatic logic [31:0] expect_word(logic [31:0] addr);
        case (addr)
            0, 1, 2, 3, 4: return model[addr[2:0]];
            5:             return status.frame_save_num;
            7:             return {31'd0, status.frame_notready};
            8:             return status.frame_height_width;
            9:             return status.frame_de_num;
            default:       return 32'hffff_ffff;
        endcase
    endfunction

    function automatic int all_errors();
        return errors + uut.u_props.fail_cnt;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic handshake(input int ch);
        bit hs;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            case (ch)
                0:       hs = aw_ready;
                1:       hs = w_ready;
                default: hs = ar_ready;
            endcase
            @(posedge clk);
        end
    endtask

    task automatic write_burst(input logic [31:0] addr, input int len,
                               input logic [1:0] burst, input bit throttle);
        logic [31:0]              a;
        bit                       hs;
        capture_ctrl_pkg::axi_b_t resp;
        a = addr;
        aw <= '{id: 4'(len), addr: addr, len: 8'(len), burst: burst};
        aw_valid <= 1'b1;
        handshake(0);
        aw_valid <= 1'b0;
        for (int i = 0; i <= len; i++) begin
            w <= '{data: wdata[i], strb: 4'hf, last: (i == len)};
            w_valid <= 1'b1;
            handshake(1);
            if (a <= 4)
                model[a[2:0]] = (a == 0) ? (wdata[i] & 32'h0000_0101) : wdata[i];
            if (burst == capture_ctrl_pkg::BURST_INCR)
                a++;
        end
        w_valid <= 1'b0;
        hs = 1'b0;
        while (!hs) begin
            b_ready <= throttle ? rand_bit() : 1'b1;
            @(negedge clk);
            hs   = b_valid && b_ready;
            resp = b;
            @(posedge clk);
        end
        b_ready <= 1'b0;
        compare_word("write resp", {30'd0, resp.resp}, {30'd0, resp_for(burst)});
        compare_word("write id", {28'd0, resp.id}, {28'd0, 4'(len)});
    endtask

    task automatic read_burst(input logic [31:0] addr, input int len,
                              input logic [1:0] burst, input bit throttle);
        logic [31:0]              a;
        bit                       hs;
        capture_ctrl_pkg::axi_r_t beat;
        a = addr;
        ar <= '{id: 4'(len), addr: addr, len: 8'(len), burst: burst};
        ar_valid <= 1'b1;
        handshake(2);
        ar_valid <= 1'b0;
        for (int k = 0; k <= len; k++) begin
            hs = 1'b0;
            while (!hs) begin
                r_ready <= throttle ? rand_bit() : 1'b1;
                @(negedge clk);
                hs   = r_valid && r_ready;
                beat = r;
                @(posedge clk);
            end
            compare_word($sformatf("read data at %0d", a), beat.data, expect_word(a));
            compare_word("read resp", {30'd0, beat.resp}, {30'd0, resp_for(burst)});
            compare_word("read last", {31'd0, beat.last}, {31'd0, k == len});
            compare_word("read id", {28'd0, beat.id}, {28'd0, 4'(len)});
            if (burst == capture_ctrl_pkg::BURST_INCR)
                a++;
        end
        r_ready <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (all_errors() == err_mark) begin
            $display("test %-30s ok", name);
        end else begin
            $display("test %-30s FAILED (%0d errors)", name, all_errors() - err_mark);
            tests_failed++;
        end
        err_mark = all_errors();
    endtask

    initial begin
        hdmi_rstn_sync = 1'b0;
        aw             = '0;
        ar             = '0;
        w              = '0;
        aw_valid       = 1'b0;
        w_valid        = 1'b0;
        b_ready        = 1'b0;
        ar_valid       = 1'b0;
        r_ready        = 1'b0;
        status = '{frame_notready: 1'b1, frame_height_width: 32'h0438_0780,
                   frame_de_num: 32'h001f_a400, frame_save_num: 32'd17,
                   total_need_frame_num: 32'd34};
        for (int i = 0; i < 5; i++)
            model[i] = '0;
        repeat (10) @(posedge clk);
        hdmi_rstn_sync <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < 4; i++)
            wdata[i] = rand_word();
        write_burst(1, 3, capture_ctrl_pkg::BURST_INCR, 1'b0);
        read_burst(1, 3, capture_ctrl_pkg::BURST_INCR, 1'b0);
        compare_word("ctrl.start_write_addr", ctrl.start_write_addr, model[1]);
        compare_word("ctrl.end_write_addr", ctrl.end_write_addr, model[2]);
        compare_word("ctrl.capture_frame_sequence", ctrl.capture_frame_sequence, model[3]);
        finish_test("incr write and readback");

        for (int i = 0; i < 3; i++)
            wdata[i] = rand_word();
        write_burst(0, 2, capture_ctrl_pkg::BURST_FIXED, 1'b0);
        read_burst(0, 0, capture_ctrl_pkg::BURST_FIXED, 1'b0);
        compare_word("ctrl.capture_on", {31'd0, ctrl.capture_on}, {31'd0, wdata[2][0]});
        compare_word("ctrl.capture_rst", {31'd0, ctrl.capture_rst}, {31'd0, wdata[2][8]});
        finish_test("fixed write to capture ctrl");

        read_burst(5, 4, capture_ctrl_pkg::BURST_INCR, 1'b0); // 5..9, 6 is unmapped
        read_burst(4, 0, capture_ctrl_pkg::BURST_FIXED, 1'b0);
        read_burst(20, 0, capture_ctrl_pkg::BURST_INCR, 1'b0);
        finish_test("status and unmapped reads");

        for (int i = 0; i < 2; i++)
            wdata[i] = rand_word();
        write_burst(1, 1, 2'd2, 1'b0);
        write_burst(2, 1, 2'd3, 1'b0);
        read_burst(1, 1, 2'd2, 1'b0);
        read_burst(2, 1, 2'd3, 1'b0);
        wdata[0] = rand_word();
        write_burst(2, 0, capture_ctrl_pkg::BURST_INCR, 1'b0);
        read_burst(2, 0, capture_ctrl_pkg::BURST_FIXED, 1'b0);
        finish_test("reserved burst codes");

        for (int i = 0; i < 32; i++)
            wdata[i] = rand_word();
        write_burst(0, 3, capture_ctrl_pkg::BURST_INCR, 1'b1);
        write_burst(3, 31, capture_ctrl_pkg::BURST_FIXED, 1'b1);
        read_burst(3, 31, capture_ctrl_pkg::BURST_FIXED, 1'b1);
        read_burst(0, 15, capture_ctrl_pkg::BURST_INCR, 1'b1);
        finish_test("throttled long bursts");

        pulses_before = pulses;
        wdata[0] = rand_word();
        write_burst(4, 0, capture_ctrl_pkg::BURST_INCR, 1'b0);
        repeat (3) @(posedge clk);
        compare_word("add_need_frame pulses", pulses - pulses_before, 32'd1);
        compare_word("ctrl.add_need_frame_num", ctrl.add_need_frame_num, model[4]);
        finish_test("added-frame strobe");

        $display("tests: 6 run, %0d failed; check errors: %0d; assertion failures: %0d",
                 tests_failed, errors, uut.u_props.fail_cnt);
        if (all_errors() == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== capture_ctrl_slave.f ====
verilog/capture_ctrl_pkg.sv
verilog/axi_wr_channel.sv
verilog/axi_rd_channel.sv
verilog/capture_reg_bank.sv
verilog/capture_ctrl_slave.sv
bench/capture_ctrl_slave_props.sv
bench/capture_ctrl_slave_tb.sv

// ==== verilog/axi_rd_channel.sv ====
`timescale 1ns/1ns
module axi_rd_channel (
    input  logic                                    clk,
    input  logic                                    hdmi_rstn_sync,
    input  capture_ctrl_pkg::axi_aw_t               ar,
    input  logic                                    ar_valid,
    output logic                                    ar_ready,
    output capture_ctrl_pkg::axi_r_t                r,
    output logic                                    r_valid,
    input  logic                                    r_ready,
    output logic [capture_ctrl_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  logic [capture_ctrl_pkg::DATA_WIDTH-1:0] rd_data
);

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    rd_state_e state, state_nxt;

    logic [capture_ctrl_pkg::ID_WIDTH-1:0]  id_q;
    logic [capture_ctrl_pkg::LEN_WIDTH-1:0] len_q;
    logic [capture_ctrl_pkg::LEN_WIDTH-1:0] beat_cnt;
    logic [1:0]                             burst_q;
    logic                                   ar_fire;
    logic                                   r_fire;
    logic                                   last_beat;
    logic                                   burst_rsvd;

    assign ar_fire    = ar_valid && ar_ready;
    assign r_fire     = r_valid && r_ready;
    assign last_beat  = (beat_cnt == len_q);
    assign burst_rsvd = (burst_q != capture_ctrl_pkg::BURST_FIXED) &&
                        (burst_q != capture_ctrl_pkg::BURST_INCR);

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: if (ar_fire) state_nxt = RD_DATA;
            RD_DATA: if (r_fire && last_beat) state_nxt = RD_IDLE;
            default: state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (ar_fire)
                beat_cnt <= '0;
            else if (r_fire)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // burst context, taken on AR accept
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q    <= ar.id;
            len_q   <= ar.len;
            burst_q <= ar.burst;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            rd_addr <= ar.addr;
        else if (r_fire && burst_q == capture_ctrl_pkg::BURST_INCR)
            rd_addr <= rd_addr + 1'b1;
        // fixed and reserved codes hold the address
    end

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_DATA);

    assign r.id   = id_q;
    assign r.data = rd_data; // bank decodes rd_addr combinationally
    assign r.resp = burst_rsvd ? capture_ctrl_pkg::RESP_SLVERR : capture_ctrl_pkg::RESP_OKAY;
    assign r.last = last_beat;

endmodule

// ==== verilog/axi_wr_channel.sv ====
`timescale 1ns/1ns
module axi_wr_channel (
    input  logic                        clk,
    input  logic                        hdmi_rstn_sync,
    input  capture_ctrl_pkg::axi_aw_t   aw,
    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  capture_ctrl_pkg::axi_w_t    w,
    input  logic                        w_valid,
    output logic                        w_ready,
    output capture_ctrl_pkg::axi_b_t    b,
    output logic                        b_valid,
    input  logic                        b_ready,
    output capture_ctrl_pkg::reg_wr_t   reg_wr
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e state, state_nxt;

    logic [capture_ctrl_pkg::ID_WIDTH-1:0]   id_q;
    logic [capture_ctrl_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [1:0]                              burst_q;
    logic                                    err_q;
    logic                                    aw_fire, w_fire, b_fire;
    logic                                    burst_rsvd;

    assign aw_fire    = aw_valid && aw_ready;
    assign w_fire     = w_valid && w_ready;
    assign b_fire     = b_valid && b_ready;
    assign burst_rsvd = (burst_q != capture_ctrl_pkg::BURST_FIXED) &&
                        (burst_q != capture_ctrl_pkg::BURST_INCR);

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (aw_fire) state_nxt = WR_DATA;
            WR_DATA: if (w_fire && w.last) state_nxt = WR_RESP; // len is not tracked
            WR_RESP: if (b_fire) state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            state <= WR_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == WR_IDLE)
                err_q <= 1'b0;
            else if (state == WR_DATA && burst_rsvd)
                err_q <= 1'b1; // sticky until back to idle
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q    <= aw.id;
            addr_q  <= aw.addr;
            burst_q <= aw.burst;
        end else if (w_fire && burst_q == capture_ctrl_pkg::BURST_INCR) begin
            addr_q  <= addr_q + 1'b1;
        end
    end

    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);

    assign b.id   = id_q;
    assign b.resp = err_q ? capture_ctrl_pkg::RESP_SLVERR : capture_ctrl_pkg::RESP_OKAY;

    // strobes ignored, whole word written
    assign reg_wr.en   = w_fire;
    assign reg_wr.addr = addr_q;
    assign reg_wr.data = w.data;

endmodule

// ==== verilog/capture_ctrl_pkg.sv ====
package capture_ctrl_pkg;

    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int LEN_WIDTH  = 8;

    // register map, word addressed
    localparam logic [ADDR_WIDTH-1:0] ADDR_CAPTURE_CTRL           = 32'd0;
    localparam logic [ADDR_WIDTH-1:0] ADDR_START_WRITE_ADDR       = 32'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_END_WRITE_ADDR         = 32'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_CAPTURE_FRAME_SEQUENCE = 32'd3;
    localparam logic [ADDR_WIDTH-1:0] ADDR_ADD_NEED_FRAME_NUM     = 32'd4;
    localparam logic [ADDR_WIDTH-1:0] ADDR_FRAME_SAVE_NUM         = 32'd5;
    localparam logic [ADDR_WIDTH-1:0] ADDR_FIFO_FRAME_INFO        = 32'd6; // reserved
    localparam logic [ADDR_WIDTH-1:0] ADDR_FRAME_NOTREADY         = 32'd7;
    localparam logic [ADDR_WIDTH-1:0] ADDR_FRAME_HEIGHT_WIDTH     = 32'd8;
    localparam logic [ADDR_WIDTH-1:0] ADDR_FRAME_DE_NUM           = 32'd9;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    localparam logic [DATA_WIDTH-1:0] UNMAPPED_DATA = '1;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [1:0]            burst;
    } axi_aw_t; // also used for AR

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   data;
        logic [DATA_WIDTH/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic                  capture_on;
        logic                  capture_rst;
        logic [DATA_WIDTH-1:0] start_write_addr;
        logic [DATA_WIDTH-1:0] end_write_addr;
        logic [DATA_WIDTH-1:0] capture_frame_sequence;
        logic [DATA_WIDTH-1:0] add_need_frame_num;
    } capture_ctrl_t;

    typedef struct packed {
        logic                  frame_notready;
        logic [DATA_WIDTH-1:0] frame_height_width;
        logic [DATA_WIDTH-1:0] frame_de_num;
        logic [DATA_WIDTH-1:0] frame_save_num;
        logic [DATA_WIDTH-1:0] total_need_frame_num;
    } capture_status_t;

    // capture control word, on at bit 0 and rst at bit 8
    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;
        struct packed {
            logic [22:0] rsvd_hi;
            logic        rst;
            logic [6:0]  rsvd_lo;
            logic        on;
        } ctrl;
    } ctrl_word_u;

endpackage

// ==== verilog/capture_ctrl_slave.sv ====
`timescale 1ns/1ns
module capture_ctrl_slave (
    input  logic                                clk,
    input  logic                                hdmi_rstn_sync,
    input  capture_ctrl_pkg::axi_aw_t           aw,
    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  capture_ctrl_pkg::axi_w_t            w,
    input  logic                                w_valid,
    output logic                                w_ready,
    output capture_ctrl_pkg::axi_b_t            b,
    output logic                                b_valid,
    input  logic                                b_ready,
    input  capture_ctrl_pkg::axi_aw_t           ar,
    input  logic                                ar_valid,
    output logic                                ar_ready,
    output capture_ctrl_pkg::axi_r_t            r,
    output logic                                r_valid,
    input  logic                                r_ready,
    input  capture_ctrl_pkg::capture_status_t   status,
    output capture_ctrl_pkg::capture_ctrl_t     ctrl,
    output logic                                add_need_frame
);

    capture_ctrl_pkg::reg_wr_t               reg_wr;
    logic [capture_ctrl_pkg::ADDR_WIDTH-1:0] rd_addr;
    logic [capture_ctrl_pkg::DATA_WIDTH-1:0] rd_data;

    axi_wr_channel u_axi_wr_channel (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .reg_wr         (reg_wr)
    );

    capture_reg_bank u_capture_reg_bank (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .reg_wr         (reg_wr),
        .rd_addr        (rd_addr),
        .status         (status),
        .rd_data        (rd_data),
        .ctrl           (ctrl),
        .add_need_frame (add_need_frame)
    );

    axi_rd_channel u_axi_rd_channel (
        .clk            (clk),
        .hdmi_rstn_sync (hdmi_rstn_sync),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r              (r),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

endmodule

// ==== verilog/capture_reg_bank.sv ====
`timescale 1ns/1ns
module capture_reg_bank (
    input  logic                                    clk,
    input  logic                                    hdmi_rstn_sync,
    input  capture_ctrl_pkg::reg_wr_t               reg_wr,
    input  logic [capture_ctrl_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  capture_ctrl_pkg::capture_status_t       status,
    output logic [capture_ctrl_pkg::DATA_WIDTH-1:0] rd_data,
    output capture_ctrl_pkg::capture_ctrl_t         ctrl,
    output logic                                    add_need_frame
);

    capture_ctrl_pkg::ctrl_word_u wr_word;
    capture_ctrl_pkg::ctrl_word_u rd_word;

    assign wr_word.raw = reg_wr.data;

    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync) begin
            ctrl <= '0;
        end else if (reg_wr.en) begin
            case (reg_wr.addr)
                capture_ctrl_pkg::ADDR_CAPTURE_CTRL: begin
                    ctrl.capture_on  <= wr_word.ctrl.on;
                    ctrl.capture_rst <= wr_word.ctrl.rst;
                end
                capture_ctrl_pkg::ADDR_START_WRITE_ADDR: begin
                    ctrl.start_write_addr <= wr_word.raw;
                end
                capture_ctrl_pkg::ADDR_END_WRITE_ADDR: begin
                    ctrl.end_write_addr <= wr_word.raw;
                end
                capture_ctrl_pkg::ADDR_CAPTURE_FRAME_SEQUENCE: begin
                    ctrl.capture_frame_sequence <= wr_word.raw;
                end
                capture_ctrl_pkg::ADDR_ADD_NEED_FRAME_NUM: begin
                    ctrl.add_need_frame_num <= wr_word.raw;
                end
                default: begin
                    // status and unmapped addresses drop the write
                end
            endcase
        end
    end

    // one clk pulse per write to the added-frame register
    always_ff @(posedge clk or negedge hdmi_rstn_sync) begin
        if (!hdmi_rstn_sync)
            add_need_frame <= 1'b0;
        else
            add_need_frame <= reg_wr.en &&
                              (reg_wr.addr == capture_ctrl_pkg::ADDR_ADD_NEED_FRAME_NUM);
    end

    always_comb begin
        rd_word = '0;
        case (rd_addr)
            capture_ctrl_pkg::ADDR_CAPTURE_CTRL: begin
                rd_word.ctrl.on  = ctrl.capture_on;
                rd_word.ctrl.rst = ctrl.capture_rst;
            end
            capture_ctrl_pkg::ADDR_START_WRITE_ADDR:
                rd_word.raw = ctrl.start_write_addr;
            capture_ctrl_pkg::ADDR_END_WRITE_ADDR:
                rd_word.raw = ctrl.end_write_addr;
            capture_ctrl_pkg::ADDR_CAPTURE_FRAME_SEQUENCE:
                rd_word.raw = ctrl.capture_frame_sequence;
            capture_ctrl_pkg::ADDR_ADD_NEED_FRAME_NUM:
                rd_word.raw = ctrl.add_need_frame_num;
            capture_ctrl_pkg::ADDR_FRAME_SAVE_NUM:
                rd_word.raw = status.frame_save_num;
            capture_ctrl_pkg::ADDR_FRAME_NOTREADY:
                rd_word.raw = {{(capture_ctrl_pkg::DATA_WIDTH-1){1'b0}}, status.frame_notready};
            capture_ctrl_pkg::ADDR_FRAME_HEIGHT_WIDTH:
                rd_word.raw = status.frame_height_width;
            capture_ctrl_pkg::ADDR_FRAME_DE_NUM:
                rd_word.raw = status.frame_de_num;
            default:
                rd_word.raw = capture_ctrl_pkg::UNMAPPED_DATA; // includes frame info slot
        endcase
    end

    assign rd_data = rd_word.raw;

endmodule
